//--- src/dma_rx_dmux_config.svh
`ifndef DMA_RX_DMUX_CONFIG_SVH
`define DMA_RX_DMUX_CONFIG_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------
`define DMA_CH             3
`define TDATA_W            64
`define FIFO_DEPTH         16

// words kept free below full, room drops at depth minus headroom
`define FIFO_HEADROOM      4

// --------------------------------------------------
// register bus and map
// --------------------------------------------------
`define CSR_ADDR_W         8
`define CSR_DATA_W         32
`define CSR_BASE           'h60

// offsets relative to CSR_BASE
`define CSR_DROP_EN_OFS    0
`define CSR_THRESH_OFS     4
`define CSR_THRESH_STRIDE  4

`endif

//--- src/dma_rx_stream_pkg.sv
`default_nettype none

`include "dma_rx_dmux_config.svh"

package dma_rx_stream_pkg;

   typedef logic [`TDATA_W-1:0]   tdata_t;
   typedef logic [`TDATA_W/8-1:0] tkeep_t;

   // one stream beat as stored in the egress FIFO
   typedef struct packed {
      tdata_t tdata;
      tkeep_t tkeep;
      logic   tlast;
   } beat_t;

   // switch egress ports, only the MSGDMA ones land here
   typedef enum logic [2:0] {
      ETH_0,
      ETH_1,
      MSGDMA_0,
      MSGDMA_1,
      MSGDMA_2
   } port_e;

   typedef logic [`DMA_CH-1:0] chan_mask_t;

   typedef struct packed {
      port_e      egr_port;
      logic       multicast_en;
      chan_mask_t multicast_port;
   } route_t;

   typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] occ_t;
   typedef logic [7:0]                       thresh_t;

   typedef enum logic {
      PASS,
      TRUNC
   } drop_state_e;

endpackage

`default_nettype wire

//--- src/dma_rx_csr_pkg.sv
`default_nettype none

`include "dma_rx_dmux_config.svh"

package dma_rx_csr_pkg;

   import dma_rx_stream_pkg::*;

   typedef logic [`CSR_ADDR_W-1:0]   csr_addr_t;
   typedef logic [`CSR_DATA_W-1:0]   csr_data_t;
   typedef logic [`CSR_DATA_W/8-1:0] csr_be_t;

   typedef struct packed {
      csr_addr_t address;
      logic      read;
      logic      write;
      csr_data_t writedata;
      csr_be_t   byteenable;
   } avmm_req_t;

   typedef struct packed {
      csr_data_t readdata;
      logic      readdata_valid;
   } avmm_rsp_t;

   // drop policy of one channel
   typedef struct packed {
      logic    drop_en;
      thresh_t threshold;
   } chan_cfg_t;

endpackage

`default_nettype wire

//--- src/dma_rx_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_dmux_config.svh"

module dma_rx_csr
   import dma_rx_stream_pkg::*;
   import dma_rx_csr_pkg::*;
(
   input  var logic                     clk,
   input  var logic                     rst,
   input  var avmm_req_t                avmm_req,
   output avmm_rsp_t                    avmm_rsp,
   output chan_cfg_t [`DMA_CH-1:0]      cfg
);

   localparam csr_addr_t EN_OFS = csr_addr_t'(`CSR_DROP_EN_OFS);

   csr_addr_t ofs;
   csr_data_t rd_word;
   csr_data_t rd_data_q;
   logic      rd_valid_q;

   function automatic csr_addr_t thresh_ofs(input int c);
      return csr_addr_t'(`CSR_THRESH_OFS + c * `CSR_THRESH_STRIDE);
   endfunction

   // address relative to the block base, below base wraps out of the map
   assign ofs = avmm_req.address - csr_addr_t'(`CSR_BASE);

   // --------------------------------------------------
   // write side
   // --------------------------------------------------
   // every field sits in byte lane 0
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int c = 0; c < `DMA_CH; c++) begin
            cfg[c].drop_en   <= 1'b0;
            cfg[c].threshold <= '1;
         end
      end else if (avmm_req.write && avmm_req.byteenable[0]) begin
         for (int c = 0; c < `DMA_CH; c++) begin
            if (ofs == EN_OFS)
               cfg[c].drop_en <= avmm_req.writedata[c];
            if (ofs == thresh_ofs(c))
               cfg[c].threshold <= thresh_t'(avmm_req.writedata);
         end
      end
   end

   // --------------------------------------------------
   // read side
   // --------------------------------------------------
   always_comb begin
      rd_word = '0;
      for (int c = 0; c < `DMA_CH; c++) begin
         if (ofs == EN_OFS)
            rd_word[c] = cfg[c].drop_en;
         if (ofs == thresh_ofs(c))
            rd_word = csr_data_t'(cfg[c].threshold);
      end
   end

   // data one cycle after the request, together with the valid pulse
   always_ff @(posedge clk) begin
      if (avmm_req.read)
         rd_data_q <= rd_word;
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_valid_q <= 1'b0;
      else
         rd_valid_q <= avmm_req.read;
   end

   assign avmm_rsp = '{readdata: rd_data_q, readdata_valid: rd_valid_q};

endmodule

`default_nettype wire

//--- src/dma_rx_chan_admit.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rx_chan_admit
   import dma_rx_stream_pkg::*;
   import dma_rx_csr_pkg::*;
#(
   parameter int CHAN = 0
) (
   input  var logic      clk,
   input  var logic      rst,
   input  var logic      accept,
   input  var beat_t     in_beat,
   input  var route_t    in_route,
   input  var chan_cfg_t cfg,
   input  var occ_t      occ,
   output logic          wr,
   output beat_t         wr_beat,
   output logic          drop_event
);

   localparam port_e MY_PORT = port_e'(int'(MSGDMA_0) + CHAN);

   logic        match;
   logic        hit;
   logic        over;
   logic        trunc_end;
   drop_state_e state_q;
   drop_state_e state_d;

   // --------------------------------------------------
   // route match
   // --------------------------------------------------
   always_comb begin
      if (in_route.multicast_en)
         match = in_route.multicast_port[CHAN];
      else
         match = (in_route.egr_port == MY_PORT);
   end

   assign hit = accept & match;

   // fifo filling past threshold mid packet
   assign over = cfg.drop_en & ~in_beat.tlast & (thresh_t'(occ) > cfg.threshold);

   // --------------------------------------------------
   // drop fsm
   // --------------------------------------------------
   always_comb begin
      state_d   = state_q;
      wr        = 1'b0;
      wr_beat   = in_beat;
      trunc_end = 1'b0;
      if (hit) begin
         if (state_q == TRUNC) begin
            // rest of the packet is discarded
            if (in_beat.tlast) begin
               state_d   = PASS;
               trunc_end = 1'b1;
            end
         end else if (over) begin
            // close the packet early with this beat
            wr            = 1'b1;
            wr_beat.tlast = 1'b1;
            state_d       = TRUNC;
         end else begin
            wr = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q    <= PASS;
         drop_event <= 1'b0;
      end else begin
         state_q    <= state_d;
         drop_event <= trunc_end;
      end
   end

endmodule

`default_nettype wire

//--- src/dma_rx_chan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_dmux_config.svh"

module dma_rx_chan_fifo
   import dma_rx_stream_pkg::*;
(
   input  var logic  clk,
   input  var logic  rst,
   input  var logic  wr,
   input  var beat_t wr_beat,
   output logic      out_valid,
   output beat_t     out_beat,
   input  var logic  out_ready,
   output occ_t      occ,
   output logic      room
);

   localparam int   AW         = $clog2(`FIFO_DEPTH);
   localparam occ_t ROOM_LIMIT = occ_t'(`FIFO_DEPTH - `FIFO_HEADROOM);

   beat_t          mem [`FIFO_DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic           rd;

   // show-ahead output straight from the head slot
   assign out_valid = (occ != '0);
   assign out_beat  = mem[rd_ptr];
   assign rd        = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_ptr] <= wr_beat;
   end

   // --------------------------------------------------
   // pointers, occupancy, room
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
         room   <= 1'b1;
      end else begin
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
         // one beat may still land after this drops
         room <= (occ < ROOM_LIMIT);
      end
   end

endmodule

`default_nettype wire

//--- src/dma_rx_dmux.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_dmux_config.svh"

module dma_rx_dmux
   import dma_rx_stream_pkg::*;
   import dma_rx_csr_pkg::*;
(
   input  var logic                   clk,
   input  var logic                   rst,

   // ingress from the switch
   input  var logic                   in_valid,
   output logic                       in_ready,
   input  var beat_t                  in_beat,
   input  var route_t                 in_route,

   // msgdma receive channels
   output chan_mask_t                 dma_valid,
   output beat_t [`DMA_CH-1:0]        dma_beat,
   input  var chan_mask_t             dma_ready,

   // register bus
   input  var avmm_req_t              avmm_req,
   output avmm_rsp_t                  avmm_rsp,

   output chan_mask_t                 drop_event
);

   chan_cfg_t [`DMA_CH-1:0] cfg;
   chan_mask_t              room;
   logic                    accept;

   // all channels must have room, a beat may go to several of them
   assign in_ready = &room;
   assign accept   = in_valid & in_ready;

   dma_rx_csr u_csr (
      .clk      (clk),
      .rst      (rst),
      .avmm_req (avmm_req),
      .avmm_rsp (avmm_rsp),
      .cfg      (cfg)
   );

   // --------------------------------------------------
   // per channel slice
   // --------------------------------------------------
   for (genvar c = 0; c < `DMA_CH; c++) begin : gen_chan
      logic  wr;
      beat_t wr_beat;
      occ_t  occ;

      dma_rx_chan_admit #(.CHAN(c)) u_admit (
         .clk        (clk),
         .rst        (rst),
         .accept     (accept),
         .in_beat    (in_beat),
         .in_route   (in_route),
         .cfg        (cfg[c]),
         .occ        (occ),
         .wr         (wr),
         .wr_beat    (wr_beat),
         .drop_event (drop_event[c])
      );

      dma_rx_chan_fifo u_fifo (
         .clk       (clk),
         .rst       (rst),
         .wr        (wr),
         .wr_beat   (wr_beat),
         .out_valid (dma_valid[c]),
         .out_beat  (dma_beat[c]),
         .out_ready (dma_ready[c]),
         .occ       (occ),
         .room      (room[c])
      );
   end

endmodule

`default_nettype wire

//--- dv/dma_rx_dmux_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_dmux_config.svh"

module dma_rx_dmux_tb
   import dma_rx_stream_pkg::*;
   import dma_rx_csr_pkg::*;
;

   localparam int TEST_BEATS      = 52;
   localparam int CSR_OPS         = 33;
   localparam int MARGIN          = 40;
   localparam int WATCHDOG_CYCLES = 16 + (TEST_BEATS + CSR_OPS) * MARGIN;
   localparam int STALL_LIMIT     = 32;
   localparam int IDLE_LIMIT      = 32;
   localparam int RSP_LIMIT       = 8;

   logic                clk = 1'b0;
   logic                rst;
   logic                in_valid;
   logic                in_ready;
   beat_t               in_beat;
   route_t              in_route;
   chan_mask_t          dma_valid;
   beat_t [`DMA_CH-1:0] dma_beat;
   chan_mask_t          dma_ready;
   avmm_req_t           avmm_req;
   avmm_rsp_t           avmm_rsp;
   chan_mask_t          drop_event;

   integer     seed;
   int         errors = 0;
   int         checks = 0;
   // register shadow with the enable word first and then the thresholds
   csr_data_t  shadow [4];
   beat_t      exp_q [`DMA_CH][$];
   bit         trunc_st [`DMA_CH];
   chan_mask_t drop_log[$];
   chan_mask_t exp_drop_log[$];

   always #10 clk = ~clk;

   dma_rx_dmux u_dut (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_beat    (in_beat),
      .in_route   (in_route),
      .dma_valid  (dma_valid),
      .dma_beat   (dma_beat),
      .dma_ready  (dma_ready),
      .avmm_req   (avmm_req),
      .avmm_rsp   (avmm_rsp),
      .drop_event (drop_event)
   );

   // record every drop strobe seen
   always @(negedge clk) begin
      if (!rst && drop_event != '0)
         drop_log.push_back(drop_event);
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("errors: %0d, checks: %0d", errors + 1, checks);
      $display("Errors found");
      $finish;
   end

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_beat(input string name, input beat_t exp, input beat_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input csr_data_t exp, input csr_data_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_mask(input string name, input chan_mask_t exp, input chan_mask_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic report(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // --------------------------------------------------
   // register bus and its model
   // --------------------------------------------------
   function automatic int reg_index(input csr_addr_t a);
      int ia;
      ia = int'(a);
      if (ia < `CSR_BASE || ia > `CSR_BASE + 12 || ia % 4 != 0)
         return -1;
      return (ia - `CSR_BASE) / 4;
   endfunction

   function automatic csr_data_t field_mask(input int idx);
      return (idx == 0) ? csr_data_t'((1 << `DMA_CH) - 1) : csr_data_t'(8'hFF);
   endfunction

   task automatic csr_write(input csr_addr_t a, input csr_data_t d, input csr_be_t be);
      csr_data_t lanes;
      int        idx;
      @(posedge clk);
      avmm_req <= '{address: a, read: 1'b0, write: 1'b1, writedata: d, byteenable: be};
      @(posedge clk);
      avmm_req <= '0;
      idx   = reg_index(a);
      lanes = '0;
      for (int l = 0; l < 4; l++)
         if (be[l])
            lanes[8*l +: 8] = 8'hFF;
      if (idx >= 0)
         shadow[idx] = ((shadow[idx] & ~lanes) | (d & lanes)) & field_mask(idx);
   endtask

   task automatic csr_read(input csr_addr_t a, output csr_data_t d);
      int lat;
      @(posedge clk);
      avmm_req <= '{address: a, read: 1'b1, write: 1'b0, writedata: '0, byteenable: '1};
      @(posedge clk);
      avmm_req <= '0;
      lat = 1;
      @(negedge clk);
      while (!avmm_rsp.readdata_valid && lat < RSP_LIMIT) begin
         @(negedge clk);
         lat++;
      end
      d = avmm_rsp.readdata;
      if (!avmm_rsp.readdata_valid)
         report($sformatf("no read response for address %h", a));
      else if (lat != 1)
         report($sformatf("read of %h answered after %0d cycles, not one", a, lat));
   endtask

   task automatic check_reg(input string name, input csr_addr_t a);
      csr_data_t got;
      int        idx;
      idx = reg_index(a);
      csr_read(a, got);
      check_word($sformatf("%s @%h", name, a), (idx >= 0) ? shadow[idx] : '0, got);
   endtask

   task automatic check_map(input string name);
      for (int i = 0; i < 4; i++)
         check_reg(name, csr_addr_t'(`CSR_BASE + 4 * i));
   endtask

   // --------------------------------------------------
   // stream side
   // --------------------------------------------------
   function automatic chan_mask_t route_hits(input route_t r);
      if (r.multicast_en)
         return r.multicast_port;
      case (r.egr_port)
         MSGDMA_0: return 3'b001;
         MSGDMA_1: return 3'b010;
         MSGDMA_2: return 3'b100;
         default:  return 3'b000;
      endcase
   endfunction

   function automatic route_t unicast(input port_e p);
      return '{egr_port: p, multicast_en: 1'b0, multicast_port: '0};
   endfunction

   // expected storage of one accepted beat with PASS/TRUNC per channel
   task automatic model_accept(input beat_t b, input chan_mask_t hits);
      beat_t      nb;
      chan_mask_t ends;
      ends = '0;
      for (int c = 0; c < `DMA_CH; c++) begin
         if (hits[c]) begin
            if (trunc_st[c]) begin
               if (b.tlast) begin
                  trunc_st[c] = 1'b0;
                  ends[c]     = 1'b1;
               end
            end else if (shadow[0][c] && !b.tlast &&
                         exp_q[c].size() > int'(shadow[c+1][7:0])) begin
               nb          = b;
               nb.tlast    = 1'b1;
               trunc_st[c] = 1'b1;
               exp_q[c].push_back(nb);
            end else begin
               exp_q[c].push_back(b);
            end
         end
      end
      if (ends != '0)
         exp_drop_log.push_back(ends);
   endtask

   task automatic send_packet(input route_t r, input int len, input bit may_stall,
                              output int sent);
      beat_t b;
      int    stall;
      bit    stalled;
      sent    = 0;
      stalled = 1'b0;
      @(posedge clk);
      for (int i = 0; i < len; i++) begin
         b.tdata = {$random(seed), $random(seed)};
         b.tkeep = tkeep_t'($random(seed));
         b.tlast = (i == len - 1);
         in_valid <= 1'b1;
         in_beat  <= b;
         in_route <= r;
         stall = 0;
         @(negedge clk);
         while (!in_ready && stall < STALL_LIMIT) begin
            @(negedge clk);
            stall++;
         end
         if (!in_ready) begin
            stalled = 1'b1;
            break;
         end
         @(posedge clk);
         model_accept(b, route_hits(r));
         sent++;
      end
      if (stalled)
         @(posedge clk);
      in_valid <= 1'b0;
      if (stalled && !may_stall)
         report($sformatf("in_ready stayed low, packet stopped after %0d beats", sent));
   endtask

   task automatic drain(input int c, input string name);
      beat_t exp;
      int    idle;
      @(posedge clk);
      dma_ready[c] <= 1'b1;
      idle = 0;
      while (exp_q[c].size() > 0 && idle < IDLE_LIMIT) begin
         @(negedge clk);
         if (dma_valid[c]) begin
            exp = exp_q[c].pop_front();
            check_beat($sformatf("%s ch%0d", name, c), exp, dma_beat[c]);
            idle = 0;
         end else begin
            idle++;
         end
      end
      @(posedge clk);
      dma_ready[c] <= 1'b0;
      if (exp_q[c].size() > 0)
         report($sformatf("%s: channel %0d missing %0d words", name, c, exp_q[c].size()));
      exp_q[c].delete();
      @(negedge clk);
      if (dma_valid[c])
         report($sformatf("%s: channel %0d holds extra words", name, c));
   endtask

   task automatic check_drops(input string name);
      repeat (2) @(negedge clk);
      if (drop_log.size() != exp_drop_log.size())
         report($sformatf("%s: %0d drop strobes seen, %0d expected", name,
                          drop_log.size(), exp_drop_log.size()));
      else
         for (int i = 0; i < drop_log.size(); i++)
            check_mask({name, " drop_event"}, exp_drop_log[i], drop_log[i]);
      drop_log.delete();
      exp_drop_log.delete();
   endtask

   // --------------------------------------------------
   // tests
   // --------------------------------------------------
   task automatic test_reset();
      @(negedge clk);
      if (!in_ready)
         report("in_ready is low after reset");
      check_mask("reset dma_valid", '0, dma_valid);
      check_word("reset readdata_valid", '0, csr_data_t'(avmm_rsp.readdata_valid));
      check_map("reset");
      check_reg("reset outside", 8'h70);
      check_reg("reset outside", 8'h00);
   endtask

   task automatic test_csr();
      // upper lanes only so no field changes
      csr_write(8'h60, 32'hFFFF_FFFF, 4'b1110);
      csr_write(8'h64, 32'hAABB_CC05, 4'b1110);
      csr_write(8'h60, 32'h1234_5605, 4'b0001);
      csr_write(8'h68, 32'h0000_0A11, 4'b0011);
      csr_write(8'h6C, 32'h8000_0033, 4'b1001);
      check_map("csr lanes");
      csr_write(8'h70, 32'hFFFF_FFFF, 4'b1111);
      csr_write(8'h5C, 32'hFFFF_FFFF, 4'b1111);
      csr_write(8'h61, 32'hFFFF_FFFF, 4'b1111);
      check_map("csr other addr");
      csr_write(8'h60, 32'h0, 4'b0001);
      csr_write(8'h68, 32'hFF, 4'b0001);
      csr_write(8'h6C, 32'hFF, 4'b0001);
      check_map("csr restore");
   endtask

   task automatic test_unicast();
      int sent;
      send_packet(unicast(MSGDMA_0), 3, 1'b0, sent);
      send_packet(unicast(MSGDMA_1), 4, 1'b0, sent);
      send_packet(unicast(MSGDMA_2), 5, 1'b0, sent);
      send_packet(unicast(MSGDMA_0), 2, 1'b0, sent);
      @(negedge clk);
      check_mask("unicast dma_valid", 3'b111, dma_valid);
      for (int c = 0; c < `DMA_CH; c++)
         drain(c, "unicast");
      send_packet(unicast(ETH_0), 2, 1'b0, sent);
      repeat (2) @(negedge clk);
      check_mask("unicast eth_0", 3'b000, dma_valid);
      check_drops("unicast");
   endtask

   task automatic test_multicast();
      int sent;
      send_packet('{egr_port: ETH_0, multicast_en: 1'b1, multicast_port: 3'b101},
                  4, 1'b0, sent);
      @(negedge clk);
      check_mask("multicast dma_valid", 3'b101, dma_valid);
      drain(0, "multicast");
      drain(2, "multicast");
      check_drops("multicast");
   endtask

   // threshold 2 on channel 0 so beat 3 closes the packet
   task automatic test_truncation();
      int sent;
      csr_write(8'h64, 32'h2, 4'b0001);
      csr_write(8'h60, 32'h1, 4'b0001);
      send_packet(unicast(MSGDMA_0), 6, 1'b0, sent);
      check_drops("truncation ch0");
      drain(0, "truncation");
      send_packet(unicast(MSGDMA_1), 6, 1'b0, sent);
      check_drops("truncation ch1");
      drain(1, "truncation");
      csr_write(8'h60, 32'h0, 4'b0001);
      csr_write(8'h64, 32'hFF, 4'b0001);
   endtask

   task automatic test_backpressure();
      int sent;
      send_packet(unicast(MSGDMA_2), 20, 1'b1, sent);
      @(negedge clk);
      if (in_ready)
         report("in_ready still high with channel 2 blocked");
      if (sent > 13)
         report($sformatf("channel 2 took %0d words while blocked, limit is 13", sent));
      drain(2, "backpressure");
      check_drops("backpressure");
   endtask

   initial begin
      seed      = 90473;
      rst       = 1'b1;
      in_valid  = 1'b0;
      in_beat   = '0;
      in_route  = '0;
      dma_ready = '0;
      avmm_req  = '0;
      shadow[0] = '0;
      for (int i = 1; i < 4; i++)
         shadow[i] = 32'hFF;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      test_reset();
      test_csr();
      test_unicast();
      test_multicast();
      test_truncation();
      test_backpressure();
      repeat (4) @(posedge clk);
      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- dma_rx_dmux.f
+incdir+src
src/dma_rx_stream_pkg.sv
src/dma_rx_csr_pkg.sv
src/dma_rx_csr.sv
src/dma_rx_chan_admit.sv
src/dma_rx_chan_fifo.sv
src/dma_rx_dmux.sv
dv/dma_rx_dmux_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dma_rx_dmux testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
   -f dma_rx_dmux.f \
   --top-module dma_rx_dmux_tb \
   -Mdir "$OBJ_DIR" \
   -o sim
if [ $? -ne 0 ]; then
   echo "run_sim: verilator build failed"
   exit 1
fi

"./$OBJ_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "run_sim: simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" "$LOG"; then
   echo "run_sim: PASS"
   exit 0
else
   echo "run_sim: FAIL"
   exit 1
fi
